//--- all.f
hw/board_ctrl_pkg.sv
hw/lb_decode.sv
hw/misc_regs.sv
hw/irq_regs.sv
hw/board_ctrl_top.sv
tb/board_ctrl_sva.sv
tb/board_ctrl_checker.sv
tb/tb_board_ctrl.sv

//--- hw/board_ctrl_pkg.sv
package board_ctrl_pkg;

  // ------------------------------
  // bus and source widths
  // ------------------------------

  localparam int lb_adr_w  = 4;  // bit 3 picks the block, bits 2:0 the register.
  localparam int lb_dat_w  = 8;
  localparam int irq_src_w = 3;

  // ------------------------------
  // address map
  // ------------------------------

  typedef enum logic {
    blk_misc = 1'b0,
    blk_irq  = 1'b1
  } lb_block_e;

  // offsets 6 and 7 are unused and read as zero.
  typedef enum logic [2:0] {
    misc_reset       = 3'd0,
    misc_sysconfig_0 = 3'd1,
    misc_sysconfig_1 = 3'd2,
    misc_selectmap   = 3'd3,
    misc_flash       = 3'd4,
    misc_regs        = 3'd5
  } misc_reg_e;

  typedef enum logic [2:0] {
    irq_status = 3'd0,  // sticky event bits, write 1 to clear.
    irq_mask   = 3'd1,
    irq_raw    = 3'd2   // live pin levels in the same bit order as status.
  } irq_reg_e;

endpackage

//--- hw/board_ctrl_top.sv
`timescale 1ns/1ps

module board_ctrl_top import board_ctrl_pkg::*; (
  input  logic                lb_clk,
  input  logic                lb_rst,
  input  logic                lb_stb_i,
  input  logic                lb_we_i,
  input  logic [lb_adr_w-1:0] lb_adr_i,
  input  logic [lb_dat_w-1:0] lb_dat_i,
  output logic [lb_dat_w-1:0] lb_dat_o,
  input  logic                reset_mon_i,
  input  logic [7:0]          sys_config_i,
  input  logic [3:0]          user_dip_i,
  input  logic [3:0]          config_dip_i,
  input  logic                eeprom_0_wp_i,
  input  logic                eeprom_1_wp_i,
  input  logic                flash_wp_n_i,
  input  logic                flash_busy_n_i,
  input  logic                serial_busy_i,
  output logic                por_force_n_o,
  output logic                gig_eth_reset_n_o,
  output logic                boot_conf_oen_o,
  output logic [1:0]          user_led_o,
  output logic                serial_abort_o,
  output logic                irq_o
);

  logic                misc_stb;
  logic                irq_stb;
  logic [lb_dat_w-1:0] misc_dat;
  logic [lb_dat_w-1:0] irq_dat;

  lb_decode lb_decode_i (
    .lb_stb_i   (lb_stb_i),
    .lb_adr_i   (lb_adr_i),
    .misc_dat_i (misc_dat),
    .irq_dat_i  (irq_dat),
    .misc_stb_o (misc_stb),
    .irq_stb_o  (irq_stb),
    .lb_dat_o   (lb_dat_o)
  );

  // both blocks see the register offset and write data, only the strobe is steered.
  misc_regs misc_regs_i (
    .lb_clk (lb_clk), .lb_rst (lb_rst), .stb_i (misc_stb), .we_i (lb_we_i),
    .adr_i (lb_adr_i[lb_adr_w-2:0]), .dat_i (lb_dat_i), .dat_o (misc_dat),
    .reset_mon_i (reset_mon_i), .sys_config_i (sys_config_i),
    .user_dip_i (user_dip_i), .config_dip_i (config_dip_i),
    .eeprom_0_wp_i (eeprom_0_wp_i), .eeprom_1_wp_i (eeprom_1_wp_i),
    .flash_wp_n_i (flash_wp_n_i), .flash_busy_n_i (flash_busy_n_i),
    .serial_busy_i (serial_busy_i), .por_force_n_o (por_force_n_o),
    .gig_eth_reset_n_o (gig_eth_reset_n_o), .boot_conf_oen_o (boot_conf_oen_o),
    .user_led_o (user_led_o), .serial_abort_o (serial_abort_o)
  );

  irq_regs irq_regs_i (
    .lb_clk (lb_clk), .lb_rst (lb_rst), .stb_i (irq_stb), .we_i (lb_we_i),
    .adr_i (lb_adr_i[lb_adr_w-2:0]), .dat_i (lb_dat_i),
    .flash_busy_n_i (flash_busy_n_i), .serial_busy_i (serial_busy_i),
    .reset_mon_i (reset_mon_i), .dat_o (irq_dat), .irq_o (irq_o)
  );

endmodule

//--- hw/irq_regs.sv
`timescale 1ns/1ps

module irq_regs import board_ctrl_pkg::*; (
  input  logic                lb_clk,
  input  logic                lb_rst,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [lb_adr_w-2:0] adr_i,
  input  logic [lb_dat_w-1:0] dat_i,
  input  logic                flash_busy_n_i,
  input  logic                serial_busy_i,
  input  logic                reset_mon_i,
  output logic [lb_dat_w-1:0] dat_o,
  output logic                irq_o
);

  irq_reg_e             reg_sel;
  logic                 wr_en;
  logic [irq_src_w-1:0] pin_lvl;
  logic [irq_src_w-1:0] pin_s;     // first sample of the board pins.
  logic [irq_src_w-1:0] pin_h;     // previous sample for edge detection.
  logic [irq_src_w-1:0] evt;
  logic [irq_src_w-1:0] clr;
  logic [irq_src_w-1:0] status_q;
  logic [irq_src_w-1:0] mask_q;

  assign reg_sel = irq_reg_e'(adr_i);
  assign wr_en   = stb_i & we_i;
  assign pin_lvl = {reset_mon_i, serial_busy_i, flash_busy_n_i};

  // ------------------------------
  // edge detection
  // ------------------------------

  assign evt[0] = pin_s[0] & ~pin_h[0];  // flash ready.
  assign evt[1] = ~pin_s[1] & pin_h[1];  // serial done.
  assign evt[2] = pin_s[2] & ~pin_h[2];  // reset monitor asserted.

  assign clr = (wr_en && reg_sel == irq_status) ? dat_i[irq_src_w-1:0] : '0;

  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      // both stages take the live levels so release does not look like an edge.
      pin_s    <= pin_lvl;
      pin_h    <= pin_lvl;
      status_q <= '0;
      mask_q   <= '0;
    end else begin
      pin_s    <= pin_lvl;
      pin_h    <= pin_s;
      status_q <= (status_q & ~clr) | evt;  // a new event wins over a clear.
      if (wr_en && reg_sel == irq_mask) begin
        mask_q <= dat_i[irq_src_w-1:0];
      end
    end
  end

  assign irq_o = |(status_q & mask_q);

  // ------------------------------
  // read mux
  // ------------------------------

  always_comb begin
    case (reg_sel)
      irq_status: dat_o = {{(lb_dat_w-irq_src_w){1'b0}}, status_q};
      irq_mask:   dat_o = {{(lb_dat_w-irq_src_w){1'b0}}, mask_q};
      irq_raw:    dat_o = {{(lb_dat_w-irq_src_w){1'b0}}, pin_lvl};
      default:    dat_o = '0;
    endcase
  end

endmodule

//--- hw/lb_decode.sv
`timescale 1ns/1ps

module lb_decode import board_ctrl_pkg::*; (
  input  logic                lb_stb_i,
  input  logic [lb_adr_w-1:0] lb_adr_i,
  input  logic [lb_dat_w-1:0] misc_dat_i,
  input  logic [lb_dat_w-1:0] irq_dat_i,
  output logic                misc_stb_o,
  output logic                irq_stb_o,
  output logic [lb_dat_w-1:0] lb_dat_o
);

  lb_block_e blk_sel;

  // the top address bit chooses the block.
  assign blk_sel = lb_block_e'(lb_adr_i[lb_adr_w-1]);

  // ------------------------------
  // strobe steering and read mux
  // ------------------------------

  always_comb begin
    misc_stb_o = 1'b0;
    irq_stb_o  = 1'b0;
    case (blk_sel)
      blk_irq: begin
        irq_stb_o = lb_stb_i;
        lb_dat_o  = irq_dat_i;
      end
      default: begin
        misc_stb_o = lb_stb_i;
        lb_dat_o   = misc_dat_i;  // read data does not depend on the strobe.
      end
    endcase
  end

endmodule

//--- hw/misc_regs.sv
`timescale 1ns/1ps

module misc_regs import board_ctrl_pkg::*; (
  input  logic                lb_clk,
  input  logic                lb_rst,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [lb_adr_w-2:0] adr_i,
  input  logic [lb_dat_w-1:0] dat_i,
  output logic [lb_dat_w-1:0] dat_o,
  input  logic                reset_mon_i,
  input  logic [7:0]          sys_config_i,
  input  logic [3:0]          user_dip_i,
  input  logic [3:0]          config_dip_i,
  input  logic                eeprom_0_wp_i,
  input  logic                eeprom_1_wp_i,
  input  logic                flash_wp_n_i,
  input  logic                flash_busy_n_i,
  input  logic                serial_busy_i,
  output logic                por_force_n_o,
  output logic                gig_eth_reset_n_o,
  output logic                boot_conf_oen_o,
  output logic [1:0]          user_led_o,
  output logic                serial_abort_o
);

  misc_reg_e reg_sel;
  logic      wr_en;

  assign reg_sel = misc_reg_e'(adr_i);
  assign wr_en   = stb_i & we_i;

  // ------------------------------
  // read mux
  // ------------------------------

  always_comb begin
    case (reg_sel)
      misc_reset:       dat_o = {6'b0, ~gig_eth_reset_n_o, ~por_force_n_o};
      misc_sysconfig_0: dat_o = {config_dip_i, user_dip_i};
      misc_sysconfig_1: dat_o = sys_config_i;
      misc_selectmap:   dat_o = {6'b0, serial_abort_o, serial_busy_i};
      misc_flash: begin
        dat_o = {4'b0, eeprom_1_wp_i, eeprom_0_wp_i, flash_wp_n_i, flash_busy_n_i};
      end
      misc_regs:        dat_o = {5'b0, boot_conf_oen_o, user_led_o};
      default:          dat_o = '0;  // offsets 6 and 7.
    endcase
  end

  // ------------------------------
  // control registers
  // ------------------------------

  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      por_force_n_o     <= 1'b1;
      gig_eth_reset_n_o <= 1'b1;
      boot_conf_oen_o   <= 1'b1;
      user_led_o        <= 2'b00;
      serial_abort_o    <= 1'b0;
    end else begin
      // the monitor drives the POR force unless a write overrides it this cycle.
      por_force_n_o <= ~reset_mon_i;
      if (wr_en) begin
        case (reg_sel)
          misc_reset: begin
            por_force_n_o     <= ~(dat_i[0] | reset_mon_i);  // one cycle pulse.
            gig_eth_reset_n_o <= ~dat_i[1];  // held until rewritten.
          end
          misc_selectmap: serial_abort_o <= dat_i[1];
          misc_regs: begin
            user_led_o      <= dat_i[1:0];
            boot_conf_oen_o <= dat_i[2];
          end
          default: ;  // the other offsets are read only.
        endcase
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_board_ctrl -f all.f

# the pipeline status is that of grep, so a missing pass line fails the script.
./obj_dir/Vtb_board_ctrl | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null
echo "simulation passed"

//--- tb/board_ctrl_cases.txt
# name op field data expect, numbers in hex. P sets pin <field>, W and R use bus address <field>.
# E compares {irq, abort, led[1:0], boot_oen, phy_rst_n, por_n}, I idles <data> cycles.
rst_pins   E 0 00 07
rst_reset  R 0 00 00
rst_regs   R 5 00 04
rst_status R 8 00 00
rst_mask   R 9 00 00
led_wr     W 5 02 00
led_pins   E 0 00 13
led_rd     R 5 00 02
phy_wr     W 0 02 00
phy_pins   E 0 00 11
phy_rd     R 0 00 02
phy_rel    W 0 00 00
sys_pin    P 1 a5 00
dip_pin    P 2 03 00
cfg_pin    P 3 0c 00
sys0_rd    R 1 00 c3
sys1_wr    W 2 ff 00
sys1_rd    R 2 00 a5
eep_pin    P 5 01 00
wp_pin     P 6 00 00
flash_wr   W 4 ff 00
flash_rd   R 4 00 08
smap_rd    R 3 00 01
off6_rd    R 6 00 00
off7_rd    R 7 00 00
por_wr     W 0 01 00
por_low    E 0 00 12
por_back   E 0 00 13
mon_hi     P 0 01 00
mon_pins   E 0 00 12
mon_lo     P 0 00 00
abort_wr   W 3 02 00
abort_pins E 0 00 33
abort_rd   R 3 00 03
clr_all    W 8 07 00
fr_pin     P 7 01 00
fr_wait    I 0 01 00
fr_status  R 8 00 01
fr_nomask  E 0 00 33
mask_wr    W 9 01 00
irq_pins   E 0 00 73
st_clr     W 8 01 00
irq_drop   E 0 00 33
sb_pin     P 8 00 00
sb_wait    I 0 01 00
sb_status  R 8 00 02
raw_rd     R a 00 01
tail       I 0 04 00

//--- tb/board_ctrl_checker.sv
`timescale 1ns/1ps

module board_ctrl_checker import board_ctrl_pkg::*; (
  input  logic                lb_clk,
  input  logic                chk_valid_i,
  input  logic                chk_pins_i,   // high compares the pin vector, low the read data.
  input  logic [7:0]          chk_exp_i,
  input  logic [8*16-1:0]     chk_name_i,
  input  logic [lb_dat_w-1:0] lb_dat_i,
  input  logic [6:0]          pins_i,
  output int                  chk_cnt_o,
  output int                  err_cnt_o
);

  int         chk_cnt = 0;
  int         err_cnt = 0;
  logic [7:0] actual;

  assign actual    = chk_pins_i ? {1'b0, pins_i} : lb_dat_i;
  assign chk_cnt_o = chk_cnt;
  assign err_cnt_o = err_cnt;

  // ------------------------------
  // compare
  // ------------------------------

  // sampled half a cycle after the edge that set up the case.
  always @(negedge lb_clk) begin
    if (chk_valid_i) begin
      chk_cnt <= chk_cnt + 1;
      if (actual !== chk_exp_i) begin
        err_cnt <= err_cnt + 1;
        if (chk_pins_i) begin
          $display("mismatch %0s pins: expected %02h, actual %02h",
                   chk_name_i, chk_exp_i, actual);
        end else begin
          $display("mismatch %0s lb_dat_o: expected %02h, actual %02h",
                   chk_name_i, chk_exp_i, actual);
        end
      end
    end
  end

endmodule

//--- tb/board_ctrl_sva.sv
`timescale 1ns/1ps

module board_ctrl_sva import board_ctrl_pkg::*; (
  input logic                 lb_clk,
  input logic                 lb_rst,
  input logic                 lb_stb_i,
  input logic                 lb_we_i,
  input logic [lb_adr_w-1:0]  lb_adr_i,
  input logic [lb_dat_w-1:0]  lb_dat_i,
  input logic                 reset_mon_i,
  input logic                 por_n_i,
  input logic                 phy_rst_n_i,
  input logic                 boot_oen_i,
  input logic [1:0]           user_led_i,
  input logic                 abort_i,
  input logic                 irq_i
);

  int                   rst_fails = 0;
  int                   irq_fails = 0;
  int                   por_fails = 0;
  int                   fail_cnt;
  logic                 por_wr;
  logic                 mask_wr;
  logic [irq_src_w-1:0] mask_seen;

  assign fail_cnt = rst_fails + irq_fails + por_fails;
  assign por_wr   = lb_stb_i && lb_we_i && lb_adr_i == {blk_misc, misc_reset} && lb_dat_i[0];
  assign mask_wr  = lb_stb_i && lb_we_i && lb_adr_i == {blk_irq, irq_mask};

  // mask as last written over the bus.
  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      mask_seen <= '0;
    end else if (mask_wr) begin
      mask_seen <= lb_dat_i[irq_src_w-1:0];
    end
  end

  // the first reset edge loads the values, every later one must keep them.
  assert property (@(posedge lb_clk) lb_rst && $past(lb_rst) |->
      por_n_i && phy_rst_n_i && boot_oen_i && user_led_i == 2'b00 && !abort_i && !irq_i)
    else begin
      $error("outputs left their reset values while lb_rst was high");
      rst_fails++;
    end

  assert property (@(posedge lb_clk) disable iff (lb_rst) mask_seen == '0 |-> !irq_i)
    else begin
      $error("irq_o is high with every source masked");
      irq_fails++;
    end

  // with the monitor low the force drops for one cycle and then returns high.
  assert property (@(posedge lb_clk) disable iff (lb_rst)
      (por_wr && !reset_mon_i) ##1 (!por_wr && !reset_mon_i) |-> !por_n_i ##1 por_n_i)
    else begin
      $error("por_force_n_o did not pulse low for exactly one cycle");
      por_fails++;
    end

endmodule

bind board_ctrl_top board_ctrl_sva board_ctrl_sva_i (
  .lb_clk      (lb_clk),
  .lb_rst      (lb_rst),
  .lb_stb_i    (lb_stb_i),
  .lb_we_i     (lb_we_i),
  .lb_adr_i    (lb_adr_i),
  .lb_dat_i    (lb_dat_i),
  .reset_mon_i (reset_mon_i),
  .por_n_i     (por_force_n_o),
  .phy_rst_n_i (gig_eth_reset_n_o),
  .boot_oen_i  (boot_conf_oen_o),
  .user_led_i  (user_led_o),
  .abort_i     (serial_abort_o),
  .irq_i       (irq_o)
);

//--- tb/tb_board_ctrl.sv
`timescale 1ns/1ps

module tb_board_ctrl import board_ctrl_pkg::*; ();

  localparam int idle_limit = 100;
  localparam int line_limit = 200;

  logic                lb_clk = 1'b0;
  logic                lb_rst;
  logic                lb_stb_i;
  logic                lb_we_i;
  logic [lb_adr_w-1:0] lb_adr_i;
  logic [lb_dat_w-1:0] lb_dat_i;
  logic [lb_dat_w-1:0] lb_dat_o;
  logic                reset_mon_i;
  logic [7:0]          sys_config_i;
  logic [3:0]          user_dip_i;
  logic [3:0]          config_dip_i;
  logic                eeprom_0_wp_i;
  logic                eeprom_1_wp_i;
  logic                flash_wp_n_i;
  logic                flash_busy_n_i;
  logic                serial_busy_i;
  logic                por_force_n_o;
  logic                gig_eth_reset_n_o;
  logic                boot_conf_oen_o;
  logic [1:0]          user_led_o;
  logic                serial_abort_o;
  logic                irq_o;
  logic [6:0]          out_pins;
  logic                chk_valid;
  logic                chk_pins;
  logic [7:0]          chk_exp;
  logic [8*16-1:0]     chk_name;
  int                  chk_cnt;
  int                  err_cnt;
  int                  tb_errs = 0;

  always #4 lb_clk = ~lb_clk;

  assign out_pins = {irq_o, serial_abort_o, user_led_o, boot_conf_oen_o,
                     gig_eth_reset_n_o, por_force_n_o};

  board_ctrl_top board_ctrl_top_i (.*);

  board_ctrl_checker board_ctrl_checker_i (
    .lb_clk (lb_clk), .chk_valid_i (chk_valid), .chk_pins_i (chk_pins),
    .chk_exp_i (chk_exp), .chk_name_i (chk_name), .lb_dat_i (lb_dat_o),
    .pins_i (out_pins), .chk_cnt_o (chk_cnt), .err_cnt_o (err_cnt)
  );

  // ------------------------------
  // case execution
  // ------------------------------

  task automatic set_pin(input logic [8*16-1:0] name, input logic [3:0] pin,
                         input logic [7:0] val);
    case (pin)
      4'h0: reset_mon_i <= val[0];
      4'h1: sys_config_i <= val;
      4'h2: user_dip_i <= val[3:0];
      4'h3: config_dip_i <= val[3:0];
      4'h4: eeprom_0_wp_i <= val[0];
      4'h5: eeprom_1_wp_i <= val[0];
      4'h6: flash_wp_n_i <= val[0];
      4'h7: flash_busy_n_i <= val[0];
      4'h8: serial_busy_i <= val[0];
      default: begin
        $display("error: case %0s names pin %0d, which does not exist", name, pin);
        tb_errs++;
      end
    endcase
  endtask

  // every case starts on a rising edge and idles the bus unless it writes.
  task automatic run_case(input logic [8*16-1:0] name, input logic [7:0] op,
                          input logic [31:0] field, input logic [31:0] data,
                          input logic [31:0] exp_val);
    int n;
    @(posedge lb_clk);
    lb_stb_i  <= 1'b0;
    lb_we_i   <= 1'b0;
    chk_valid <= 1'b0;
    case (op)
      "P": set_pin(name, field[3:0], data[7:0]);
      "W": begin
        lb_stb_i <= 1'b1;
        lb_we_i  <= 1'b1;
        lb_adr_i <= field[lb_adr_w-1:0];
        lb_dat_i <= data[lb_dat_w-1:0];
      end
      "R", "E": begin
        if (op == "R") lb_adr_i <= field[lb_adr_w-1:0];
        chk_valid <= 1'b1;
        chk_pins  <= (op == "E");
        chk_exp   <= exp_val[7:0];
        chk_name  <= name;
      end
      "I": begin
        if (data > idle_limit) begin
          $display("timeout: idle case %0s wants %0d cycles, more than %0d",
                   name, data, idle_limit);
          tb_errs++;
        end else begin
          n = 1;  // the edge above is the first idle cycle.
          while (n < data && n < idle_limit) begin
            @(posedge lb_clk);
            n++;
          end
        end
      end
      default: begin
        $display("error: case %0s has an unknown operation", name);
        tb_errs++;
      end
    endcase
  endtask

  initial begin
    int              fd;
    int              got;
    int              nf;
    int              line_cnt;
    int              total;
    string           line;
    logic [8*16-1:0] name;
    logic [7:0]      op;
    logic [31:0]     field;
    logic [31:0]     data;
    logic [31:0]     exp_val;
    lb_rst = 1'b1;
    lb_stb_i = 1'b0;
    lb_we_i = 1'b0;
    lb_adr_i = '0;
    lb_dat_i = '0;
    reset_mon_i = 1'b0;
    sys_config_i = 8'h00;
    user_dip_i = 4'h0;
    config_dip_i = 4'h0;
    eeprom_0_wp_i = 1'b0;
    eeprom_1_wp_i = 1'b0;
    flash_wp_n_i = 1'b1;
    flash_busy_n_i = 1'b0;  // flash starts busy.
    serial_busy_i = 1'b1;
    chk_valid = 1'b0;
    chk_pins = 1'b0;
    chk_exp = 8'h00;
    chk_name = '0;
    line_cnt = 0;
    for (int i = 0; i < 5; i++) @(posedge lb_clk);
    lb_rst <= 1'b0;
    fd = $fopen("tb/board_ctrl_cases.txt", "r");
    if (fd == 0) begin
      $display("error: the case file tb/board_ctrl_cases.txt could not be opened");
      tb_errs++;
    end else begin
      while (!$feof(fd) && line_cnt < line_limit) begin
        got = $fgets(line, fd);
        line_cnt++;
        if (got > 0 && line.getc(0) != "#") begin
          nf = $sscanf(line, "%s %s %h %h %h", name, op, field, data, exp_val);
          if (nf == 5) begin
            run_case(name, op, field, data, exp_val);
          end else if (nf > 0) begin
            $display("error: line %0d of the case file is malformed", line_cnt);
            tb_errs++;
          end
        end
      end
      if (!$feof(fd)) begin
        $display("timeout: case file still not finished after %0d lines", line_limit);
        tb_errs++;
      end
      $fclose(fd);
    end
    @(posedge lb_clk);
    lb_stb_i  <= 1'b0;
    lb_we_i   <= 1'b0;
    chk_valid <= 1'b0;
    @(posedge lb_clk);
    total = tb_errs + err_cnt + board_ctrl_top_i.board_ctrl_sva_i.fail_cnt;
    $display("tb_board_ctrl: %0d checks, %0d compare errors, %0d other errors, %0d total",
             chk_cnt, err_cnt, total - err_cnt, total);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
